/* verilog/video_pkg.sv */
package video_pkg;

	// ----------------------------------------
	// display raster
	// ----------------------------------------
	localparam int H_ACTIVE = 64;		// visible columns
	localparam int V_ACTIVE = 48;		// visible lines
	localparam int H_TOTAL = 80;		// columns incl blanking
	localparam int V_TOTAL = 52;		// lines incl blanking
	localparam int H_SYNC_START = 68;	// first hsync column
	localparam int H_SYNC_END = 71;		// last hsync column, inclusive
	localparam int V_SYNC_START = 49;
	localparam int V_SYNC_END = 50;

	// ----------------------------------------
	// camera frame, one tile of the display
	// ----------------------------------------
	localparam int CAM_W = 32;
	localparam int CAM_H = 24;
	localparam int FRAME_WORDS = 768;	// CAM_W * CAM_H
	localparam int ADDR_W = 10;

	// counters to pins: map reg, buffer read, blend reg
	localparam int PIPE_DEPTH = 3;

	typedef struct packed {
		logic [6:0] x;
		logic [6:0] y;
	} coord_t;

	// 4:4:4 pixel, r in the low nibble
	typedef struct packed {
		logic [3:0] b;
		logic [3:0] g;
		logic [3:0] r;
	} pixel_t;

	typedef struct packed {
		logic hs;
		logic vs;
		logic de;
	} sync_t;

	// raw camera port, one byte per clock while href
	typedef struct packed {
		logic       vsync;
		logic       href;
		logic [7:0] d;
	} cam_bus_t;

endpackage

/* verilog/blend_pkg.sv */
package blend_pkg;

	// quadrant order: 1 top left, 2 top right, 3 bottom left, 4 bottom right
	typedef enum logic [1:0] {
		CAM_1 = 2'd0,
		CAM_2 = 2'd1,
		CAM_3 = 2'd2,
		CAM_4 = 2'd3
	} cam_id_t;

	typedef enum logic [1:0] {
		REG_TILE  = 2'd0,	// single camera
		REG_VSEAM = 2'd1,	// left/right mix around the middle column
		REG_HSEAM = 2'd2	// top/bottom mix around the middle line
	} region_t;

	// ----------------------------------------
	// weights, full scale is 1 << WEIGHT_SHIFT
	// ----------------------------------------
	localparam int WEIGHT_ONE = 32;
	localparam int WEIGHT_SHIFT = 5;
	localparam int WEIGHT_STEP = 4;		// per column or line across a seam
	localparam int SEAM_HALF = 4;		// seam width on each side of the boundary

	typedef struct packed {
		region_t                      region;
		cam_id_t                      src_a;	// weighted by WEIGHT_ONE - w_b
		cam_id_t                      src_b;
		logic [5:0]                   w_b;
		logic [video_pkg::ADDR_W-1:0] rd_addr;	// same tile address for all buffers
	} blend_ctrl_t;

endpackage

/* verilog/cam_capture.sv */
`timescale 1ns/1ns

module cam_capture
(
	input  logic                         clk_25M,
	input  logic                         reset,
	input  video_pkg::cam_bus_t          cam,
	output logic                         wr_en,
	output logic [video_pkg::ADDR_W-1:0] wr_addr,
	output video_pkg::pixel_t            wr_pixel
);

	import video_pkg::*;

	logic       phase;		// 0 = expecting first byte of a pair
	logic [7:0] first_byte;
	logic [ADDR_W-1:0] addr;

	assign wr_addr = addr;

	// ----------------------------------------
	// byte phase and write address
	// ----------------------------------------
	always_ff @(posedge clk_25M)
	begin
		if (reset)
		begin
			phase <= 1'b0;
			addr <= '0;
			wr_en <= 1'b0;
		end
		else
		begin
			// write strobe one cycle after the second byte
			wr_en <= cam.href && phase;

			if (cam.vsync)
				addr <= '0;	// new frame, pending write still lands at old addr
			else if (wr_en)
				addr <= addr + 1'b1;	// bump after the write

			if (cam.vsync || !cam.href)
				phase <= 1'b0;
			else
				phase <= ~phase;
		end
	end

	// ----------------------------------------
	// pixel packing
	// ----------------------------------------
	always_ff @(posedge clk_25M)
	begin
		if (cam.href && !phase)
			first_byte <= cam.d;	// hold until its partner arrives
		if (cam.href && phase)
		begin
			wr_pixel.r <= first_byte[7:4];
			wr_pixel.g <= {first_byte[2:0], cam.d[7]};	// green straddles both bytes
			wr_pixel.b <= cam.d[4:1];
		end
	end

	// a camera frame must fit the buffer
	a_addr_in_frame: assert property (@(posedge clk_25M) disable iff (reset)
		wr_en |-> wr_addr < ADDR_W'(FRAME_WORDS));

endmodule

/* verilog/frame_buffer.sv */
`timescale 1ns/1ns

module frame_buffer
(
	input  logic                         clk_25M,
	input  logic                         wr_en,
	input  logic [video_pkg::ADDR_W-1:0] wr_addr,
	input  logic [11:0]                  wr_data,
	input  logic [video_pkg::ADDR_W-1:0] rd_addr,
	output logic [11:0]                  rd_data
);

	// one full camera frame, simple dual port
	logic [11:0] mem [0:video_pkg::FRAME_WORDS-1];

	// ----------------------------------------
	// write port, capture side
	// ----------------------------------------
	always_ff @(posedge clk_25M)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// ----------------------------------------
	// read port, display side
	// ----------------------------------------
	always_ff @(posedge clk_25M)
	begin
		rd_data <= mem[rd_addr];	// one cycle latency, matched in seam_blend
	end

endmodule

/* verilog/display_timing.sv */
`timescale 1ns/1ns

module display_timing
(
	input  logic              clk_25M,
	input  logic              reset,
	output video_pkg::coord_t pos,
	output logic              pos_de,
	output video_pkg::sync_t  hdmi_sync
);

	import video_pkg::*;

	logic [6:0] x_cnt;
	logic [6:0] y_cnt;
	sync_t      sync_raw;	// decoded at the counters
	sync_t      sync_pipe [PIPE_DEPTH];

	// ----------------------------------------
	// raster counters
	// ----------------------------------------
	always_ff @(posedge clk_25M)
	begin
		if (reset)
		begin
			x_cnt <= '0;
			y_cnt <= '0;
		end
		else if (x_cnt == 7'(H_TOTAL - 1))
		begin
			x_cnt <= '0;	// end of line
			if (y_cnt == 7'(V_TOTAL - 1))
				y_cnt <= '0;	// end of frame
			else
				y_cnt <= y_cnt + 7'd1;
		end
		else
			x_cnt <= x_cnt + 7'd1;
	end

	assign pos.x = x_cnt;
	assign pos.y = y_cnt;

	// ----------------------------------------
	// sync decode, all active high
	// ----------------------------------------
	always_comb
	begin
		sync_raw.de = (x_cnt < 7'(H_ACTIVE)) && (y_cnt < 7'(V_ACTIVE));
		sync_raw.hs = (x_cnt >= 7'(H_SYNC_START)) && (x_cnt <= 7'(H_SYNC_END));
		sync_raw.vs = (y_cnt >= 7'(V_SYNC_START)) && (y_cnt <= 7'(V_SYNC_END));
	end

	assign pos_de = sync_raw.de;

	// align syncs with the pixel pipeline
	always_ff @(posedge clk_25M)
	begin
		if (reset)
		begin
			for (int i = 0; i < PIPE_DEPTH; i++)
				sync_pipe[i] <= '0;	// pins quiet until the pipe fills
		end
		else
		begin
			sync_pipe[0] <= sync_raw;
			for (int i = 1; i < PIPE_DEPTH; i++)
				sync_pipe[i] <= sync_pipe[i-1];
		end
	end

	assign hdmi_sync = sync_pipe[PIPE_DEPTH-1];

	// blanking must cover both sync pulses at the pins
	a_sync_in_blank: assert property (@(posedge clk_25M) disable iff (reset)
		(hdmi_sync.hs || hdmi_sync.vs) |-> !hdmi_sync.de);

endmodule

/* verilog/seam_map.sv */
`timescale 1ns/1ns

module seam_map
(
	input  logic                   clk_25M,
	input  logic                   reset,
	input  video_pkg::coord_t      pos,
	output blend_pkg::blend_ctrl_t ctrl
);

	import video_pkg::*;
	import blend_pkg::*;

	logic        right;		// x in the right half
	logic        lower;		// y in the lower half
	logic        active;
	logic        in_vseam;
	logic        in_hseam;
	logic [6:0]  vx_off;	// column offset from seam start
	logic [6:0]  hy_off;	// line offset from seam start
	logic [4:0]  tile_x;
	logic [4:0]  tile_y;
	blend_ctrl_t nxt;

	// ----------------------------------------
	// classify position
	// ----------------------------------------
	always_comb
	begin
		right = pos.x >= 7'(CAM_W);
		lower = pos.y >= 7'(CAM_H);
		active = (pos.x < 7'(H_ACTIVE)) && (pos.y < 7'(V_ACTIVE));
		// below the seam these wrap to large values, so one compare is enough
		vx_off = pos.x - 7'(CAM_W - SEAM_HALF);
		hy_off = pos.y - 7'(CAM_H - SEAM_HALF);
		in_vseam = vx_off < 7'(2 * SEAM_HALF);
		in_hseam = hy_off < 7'(2 * SEAM_HALF);
		tile_x = pos.x[4:0];	// x mod 32
		tile_y = lower ? 5'(pos.y - 7'(CAM_H)) : pos.y[4:0];	// y mod 24

		nxt = '0;	// blanking reads address 0 of camera 1
		if (active)
		begin
			nxt.rd_addr = ADDR_W'(tile_y * CAM_W + tile_x);
			if (in_vseam)
			begin
				// vertical seam wins at the crossing
				nxt.region = REG_VSEAM;
				nxt.src_a = lower ? CAM_3 : CAM_1;
				nxt.src_b = lower ? CAM_4 : CAM_2;
				nxt.w_b = 6'(vx_off * WEIGHT_STEP);
			end
			else if (in_hseam)
			begin
				nxt.region = REG_HSEAM;
				nxt.src_a = right ? CAM_2 : CAM_1;
				nxt.src_b = right ? CAM_4 : CAM_3;
				nxt.w_b = 6'(hy_off * WEIGHT_STEP);
			end
			else
			begin
				nxt.region = REG_TILE;
				nxt.src_a = cam_id_t'({lower, right});	// quadrant camera
				nxt.src_b = nxt.src_a;
				nxt.w_b = '0;
			end
		end
	end

	// ----------------------------------------
	// pipeline stage 1
	// ----------------------------------------
	always_ff @(posedge clk_25M)
	begin
		if (reset)
			ctrl <= '0;
		else
			ctrl <= nxt;
	end

	a_weight_range: assert property (@(posedge clk_25M) disable iff (reset)
		ctrl.w_b <= 6'(WEIGHT_ONE));

endmodule

/* verilog/seam_blend.sv */
`timescale 1ns/1ns

module seam_blend
(
	input  logic                   clk_25M,
	input  logic                   reset,
	input  blend_pkg::blend_ctrl_t ctrl,
	input  logic                   de,
	input  video_pkg::pixel_t      cam_pixel [4],
	output video_pkg::pixel_t      hdmi_data
);

	import video_pkg::*;
	import blend_pkg::*;

	blend_ctrl_t ctrl_d;	// lines up with buffer read data
	pixel_t      pix_a;
	pixel_t      pix_b;
	pixel_t      mix;
	pixel_t      mix_q;

	// one channel: (a * (32 - w) + b * w) >> 5, max sum 480
	function automatic logic [3:0] mix_ch(input logic [3:0] a, input logic [3:0] b,
		input logic [5:0] w);
		logic [9:0] w_a;
		logic [9:0] acc;
		w_a = 10'(WEIGHT_ONE) - 10'(w);
		acc = 10'(a) * w_a + 10'(b) * 10'(w);
		return acc[WEIGHT_SHIFT +: 4];	// floor divide
	endfunction

	// ----------------------------------------
	// stage 2, control meets read data
	// ----------------------------------------
	always_ff @(posedge clk_25M)
	begin
		if (reset)
			ctrl_d <= '0;
		else
			ctrl_d <= ctrl;
	end

	always_comb
	begin
		pix_a = cam_pixel[ctrl_d.src_a];
		pix_b = cam_pixel[ctrl_d.src_b];
		if (ctrl_d.region == REG_TILE)
			mix = pix_a;	// straight copy, no weighting needed
		else
		begin
			mix.r = mix_ch(pix_a.r, pix_b.r, ctrl_d.w_b);
			mix.g = mix_ch(pix_a.g, pix_b.g, ctrl_d.w_b);
			mix.b = mix_ch(pix_a.b, pix_b.b, ctrl_d.w_b);
		end
	end

	// ----------------------------------------
	// stage 3, output register
	// ----------------------------------------
	always_ff @(posedge clk_25M)
	begin
		mix_q <= mix;
	end

	// de here is the pin-aligned one, same cycle as mix_q
	assign hdmi_data = de ? mix_q : '0;

endmodule

/* verilog/video_top.sv */
`timescale 1ns/1ns

module video_top
(
	input  logic                clk_25M,
	input  logic                reset,
	input  video_pkg::cam_bus_t cam [4],
	output video_pkg::sync_t    hdmi_sync,
	output video_pkg::pixel_t   hdmi_data
);

	import video_pkg::*;
	import blend_pkg::*;

	logic              wr_en [4];
	logic [ADDR_W-1:0] wr_addr [4];
	pixel_t            wr_pixel [4];
	pixel_t            rd_pixel [4];	// one per camera, same address
	coord_t            pos;
	blend_ctrl_t       ctrl;

	// ----------------------------------------
	// capture paths, one per camera
	// ----------------------------------------
	for (genvar i = 0; i < 4; i++)
	begin : g_cam
		cam_capture u_cam_capture (
			.clk_25M  (clk_25M),
			.reset    (reset),
			.cam      (cam[i]),
			.wr_en    (wr_en[i]),
			.wr_addr  (wr_addr[i]),
			.wr_pixel (wr_pixel[i])
		);

		frame_buffer u_frame_buffer (
			.clk_25M (clk_25M),
			.wr_en   (wr_en[i]),
			.wr_addr (wr_addr[i]),
			.wr_data (wr_pixel[i]),
			.rd_addr (ctrl.rd_addr),	// shared tile address
			.rd_data (rd_pixel[i])
		);
	end

	// ----------------------------------------
	// display side
	// ----------------------------------------
	display_timing u_display_timing (
		.clk_25M   (clk_25M),
		.reset     (reset),
		.pos       (pos),
		.pos_de    (),
		.hdmi_sync (hdmi_sync)
	);

	seam_map u_seam_map (
		.clk_25M (clk_25M),
		.reset   (reset),
		.pos     (pos),
		.ctrl    (ctrl)
	);

	seam_blend u_seam_blend (
		.clk_25M   (clk_25M),
		.reset     (reset),
		.ctrl      (ctrl),
		.de        (hdmi_sync.de),
		.cam_pixel (rd_pixel),
		.hdmi_data (hdmi_data)
	);

endmodule

/* bench/tb_video_top.sv */
`timescale 1ns/1ns

module tb_video_top;

	import video_pkg::*;
	import blend_pkg::*;

	localparam int RESET_CYCLES = 5;
	localparam int SEED = 32'h832bdcce;
	// two loads of about 2000 cycles, three 4160-cycle frames after each, plus margin
	localparam int TIMEOUT_CYCLES = 40000;

	logic     clk_25M;
	logic     reset;
	cam_bus_t cam [4];
	sync_t    hdmi_sync;
	pixel_t   hdmi_data;

	logic [7:0] cam_bytes [4][2*FRAME_WORDS];	// bytes as sent, per camera
	int         line_gap [4][CAM_H];		// idle cycles before each line
	pixel_t     model_frame [4][FRAME_WORDS];	// expected buffer contents

	int   pixel_errors = 0;
	int   sync_errors = 0;
	int   pixels_checked = 0;
	int   frames_checked = 0;
	int   cycle_count = 0;
	int   fill_seen = 0;
	int   fill_bad = 0;
	int   de_run = 0;		// de cycles so far in this line, the output x
	int   de_lines = 0;		// completed de lines, the output y
	int   hs_cycles = 0;	// hs cycles since the last vs rise
	int   vs_cycles = 0;
	logic frame_synced = 1'b0;	// a whole frame window is being counted
	logic prev_de = 1'b0;
	logic prev_vs = 1'b0;
	logic armed = 1'b0;		// set once a load has landed
	logic checking = 1'b0;	// current output frame is compared
	int   seed_val;

	video_top u_video_top (
		.clk_25M   (clk_25M),
		.reset     (reset),
		.cam       (cam),
		.hdmi_sync (hdmi_sync),
		.hdmi_data (hdmi_data)
	);

	initial
	begin
		clk_25M = 1'b0;
		forever #20 clk_25M = ~clk_25M;	// 40 ns period
	end

	// ----------------------------------------
	// model of capture and blend
	// ----------------------------------------
	function automatic pixel_t pack_pixel(input logic [7:0] b0, input logic [7:0] b1);
		pixel_t p;
		p.r = b0[7:4];
		p.g = {b0[2:0], b1[7]};	// three bits from the first byte
		p.b = b1[4:1];
		return p;
	endfunction

	function automatic logic [3:0] blend_channel(input int a, input int b, input int w);
		return 4'((a * (WEIGHT_ONE - w) + b * w) / WEIGHT_ONE);	// floor
	endfunction

	function automatic logic in_vseam(input int x);
		return (x >= CAM_W - SEAM_HALF) && (x < CAM_W + SEAM_HALF);
	endfunction

	function automatic logic in_hseam(input int y);
		return (y >= CAM_H - SEAM_HALF) && (y < CAM_H + SEAM_HALF);
	endfunction

	function automatic pixel_t expect_pixel(input int x, input int y);
		int     addr;
		int     a;
		int     b;
		int     w;
		pixel_t pa;
		pixel_t pb;
		pixel_t res;
		addr = (y % CAM_H) * CAM_W + (x % CAM_W);	// same tile address for all cameras
		if (in_vseam(x))
		begin
			a = (y < CAM_H) ? 0 : 2;	// 1 and 2 on top, 3 and 4 below
			b = a + 1;
			w = WEIGHT_STEP * (x - (CAM_W - SEAM_HALF));
		end
		else if (in_hseam(y))
		begin
			a = (x < CAM_W) ? 0 : 1;	// 1 and 3 left, 2 and 4 right
			b = a + 2;
			w = WEIGHT_STEP * (y - (CAM_H - SEAM_HALF));
		end
		else
		begin
			a = ((y < CAM_H) ? 0 : 2) + ((x < CAM_W) ? 0 : 1);	// quadrant camera
			b = a;
			w = 0;
		end
		pa = model_frame[a][addr];
		pb = model_frame[b][addr];
		res.r = blend_channel(pa.r, pb.r, w);
		res.g = blend_channel(pa.g, pb.g, w);
		res.b = blend_channel(pa.b, pb.b, w);
		return res;
	endfunction

	function automatic string pixel_name(input int x, input int y);
		string kind;
		kind = in_vseam(x) ? "vseam" : (in_hseam(y) ? "hseam" : "tile");
		return $sformatf("%s x=%0d y=%0d frame %0d", kind, x, y, frames_checked + 1);
	endfunction

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------
	task automatic check_pixel(input string name, input pixel_t expected, input pixel_t actual);
		if (actual !== expected)
		begin
			pixel_errors++;
			$display("error %s: expected %03h actual %03h", name, expected, actual);
		end
	endtask

	task automatic check_sync(input string name, input int expected, input int actual);
		if (actual !== expected)
		begin
			sync_errors++;
			$display("error %s: expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic report_counts();
		$display("errors: pixel %0d, sync %0d, pixels compared %0d",
			pixel_errors, sync_errors, pixels_checked);
	endtask

	// ----------------------------------------
	// camera stimulus
	// ----------------------------------------
	task automatic drive_cam(input int c, input logic vs, input logic hr, input logic [7:0] d);
		cam[c].vsync = vs;
		cam[c].href = hr;
		cam[c].d = d;
	endtask

	task automatic send_frame(input int c);
		@(posedge clk_25M);
		#2 drive_cam(c, 1'b1, 1'b0, 8'h00);	// vsync pulse, restarts the address
		@(posedge clk_25M);
		#2 drive_cam(c, 1'b0, 1'b0, 8'h00);
		for (int l = 0; l < CAM_H; l++)
		begin
			repeat (line_gap[c][l])
			begin
				@(posedge clk_25M);
				#2 drive_cam(c, 1'b0, 1'b0, 8'h00);
			end
			for (int i = 0; i < 2 * CAM_W; i++)
			begin
				@(posedge clk_25M);
				#2 drive_cam(c, 1'b0, 1'b1, cam_bytes[c][l * 2 * CAM_W + i]);
			end
		end
		@(posedge clk_25M);
		#2 drive_cam(c, 1'b0, 1'b0, 8'h00);
	endtask

	// new random frames for all cameras, model first, then the four buses in parallel
	task automatic load_frames();
		for (int c = 0; c < 4; c++)
		begin
			for (int i = 0; i < 2 * FRAME_WORDS; i++)
				cam_bytes[c][i] = 8'($urandom);
			for (int l = 0; l < CAM_H; l++)
				line_gap[c][l] = $urandom_range(5, 0);
			for (int p = 0; p < FRAME_WORDS; p++)
				model_frame[c][p] = pack_pixel(cam_bytes[c][2*p], cam_bytes[c][2*p+1]);
		end
		fork
			send_frame(0);
			send_frame(1);
			send_frame(2);
			send_frame(3);
		join
	endtask

	// ----------------------------------------
	// output monitor, sampled mid-cycle
	// ----------------------------------------
	always @(negedge clk_25M)
	begin
		if (!reset)
		begin
			if (fill_seen < PIPE_DEPTH)
			begin
				if (hdmi_sync !== 3'b000)
					fill_bad++;	// syncs must stay low until the pipe fills
				fill_seen++;
				if (fill_seen == PIPE_DEPTH)
					check_sync("sync cycles not low during fill", 0, fill_bad);
			end
			if (hdmi_sync.de && (hdmi_sync.hs || hdmi_sync.vs))
			begin
				sync_errors++;
				$display("error: sync pulse seen while de is high on output line %0d", de_lines);
			end
			if (!hdmi_sync.de)
				check_pixel($sformatf("blanking after output line %0d", de_lines),
					'0, hdmi_data);	// data forced to zero outside de
			if (hdmi_sync.de)
			begin
				if (de_run == 0 && de_lines == 0)
				begin
					checking = armed;	// first pixel of a frame
					armed = 1'b0;
				end
				if (checking && de_run < H_ACTIVE && de_lines < V_ACTIVE)
				begin
					check_pixel(pixel_name(de_run, de_lines),
						expect_pixel(de_run, de_lines), hdmi_data);
					pixels_checked++;
				end
				de_run++;
			end
			else if (prev_de)
			begin
				check_sync("de cycles in a line", H_ACTIVE, de_run);
				de_run = 0;
				de_lines++;
			end
			if (hdmi_sync.vs && !prev_vs)
			begin
				check_sync("de lines in a frame", V_ACTIVE, de_lines);
				de_lines = 0;
				if (frame_synced)
				begin
					// one whole raster lies between two vs rises
					check_sync("hs cycles in a frame",
						(H_SYNC_END - H_SYNC_START + 1) * V_TOTAL, hs_cycles);
					check_sync("vs cycles in a frame",
						(V_SYNC_END - V_SYNC_START + 1) * H_TOTAL, vs_cycles);
				end
				frame_synced = 1'b1;
				hs_cycles = 0;
				vs_cycles = 0;
				if (checking)
				begin
					frames_checked++;
					checking = 1'b0;
				end
			end
			if (hdmi_sync.hs)
				hs_cycles++;
			if (hdmi_sync.vs)
				vs_cycles++;
			prev_de = hdmi_sync.de;
			prev_vs = hdmi_sync.vs;
		end
	end

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial
	begin
		seed_val = $urandom(SEED);
		reset = 1'b1;
		for (int c = 0; c < 4; c++)
			cam[c] = '0;
		repeat (RESET_CYCLES) @(posedge clk_25M);
		#2 reset = 1'b0;

		load_frames();
		repeat (4) @(posedge clk_25M);	// last write lands a cycle after the last byte
		armed = 1'b1;
		wait (frames_checked == 1);

		load_frames();	// recapture over the stored frames
		repeat (4) @(posedge clk_25M);
		armed = 1'b1;
		wait (frames_checked == 2);

		check_sync("pixels compared", 2 * H_ACTIVE * V_ACTIVE, pixels_checked);
		report_counts();
		if (pixel_errors == 0 && sync_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// run limit
	initial
	begin
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clk_25M);
			cycle_count++;
		end
		$display("timeout: the checked frames did not finish within %0d cycles", TIMEOUT_CYCLES);
		report_counts();
		$display("*** FAILED ***");
		$finish;
	end

endmodule

/* build.f */
verilog/video_pkg.sv
verilog/blend_pkg.sv
verilog/cam_capture.sv
verilog/frame_buffer.sv
verilog/display_timing.sv
verilog/seam_map.sv
verilog/seam_blend.sv
verilog/video_top.sv
bench/tb_video_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run tb_video_top with Verilator, verdict from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module tb_video_top -Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi

echo "simulation finished without failure"
exit 0
